//--- src/mem_pkg.sv
package mem_pkg;

  // --------------------------------------------------
  // widths and sizes
  // --------------------------------------------------
  localparam int xlen = 32;
  localparam int ram_words = 256;
  localparam int ram_aw = 8; // word index width, log2 of ram_words

  // --------------------------------------------------
  // operation and state encodings
  // --------------------------------------------------
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } lsu_op_t;

  typedef enum logic [1:0] {
    arb_idle  = 2'd0,
    arb_fetch = 2'd1,
    arb_data  = 2'd2
  } arb_state_t;

endpackage

//--- src/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import mem_pkg::*; ();

  logic            req;
  logic            we;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] wdata;
  logic [3:0]      wstrb;
  logic            ack;
  logic [xlen-1:0] rdata; // valid while ack is high

  modport requester (
    output req, we, addr, wdata, wstrb,
    input  ack, rdata
  );

  modport responder (
    input  req, we, addr, wdata, wstrb,
    output ack, rdata
  );

endinterface

//--- src/load_align.sv
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
  input  logic [xlen-1:0] rdata,
  input  lsu_op_t         op,
  input  logic [1:0]      byte_off,
  output logic [xlen-1:0] result
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // byte lane picked by the two low address bits
  assign sel_byte = rdata[{byte_off, 3'b000} +: 8];
  assign sel_half = byte_off[1] ? rdata[31:16] : rdata[15:0]; // halfwords are even aligned

  always_comb begin
    case (op)
      op_lb: begin
        result = {{(xlen-8){sel_byte[7]}}, sel_byte};
      end
      op_lbu: begin
        result = {{(xlen-8){1'b0}}, sel_byte};
      end
      op_lh: begin
        result = {{(xlen-16){sel_half[15]}}, sel_half};
      end
      op_lhu: begin
        result = {{(xlen-16){1'b0}}, sel_half};
      end
      default: begin
        result = rdata; // op_lw takes the whole word
      end
    endcase
  end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  lsu_op_t         in_op,
  input  logic [xlen-1:0] in_addr,
  input  logic [xlen-1:0] in_sdata,
  input  logic [4:0]      in_rd,
  input  logic            flush,
  output logic            stall,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data,
  output logic            exc,
  output logic [xlen-1:0] exc_addr,
  mem_bus_if.requester    bus
);

  typedef enum logic [1:0] {ms_idle, ms_req, ms_rel} ms_state_t;

  ms_state_t       state;
  lsu_op_t         op_q;
  logic            kill; // write-back cancelled by flush
  logic            accept;
  logic            bad_align;
  logic            is_load_q;
  logic [xlen-1:0] ld_result;

  function automatic logic misaligned(lsu_op_t op, logic [1:0] off);
    case (op)
      op_lh, op_lhu, op_sh: misaligned = off[0];
      op_lw, op_sw:         misaligned = |off;
      default:              misaligned = 1'b0;
    endcase
  endfunction

  assign accept    = in_valid && (state == ms_idle);
  assign bad_align = misaligned(in_op, in_addr[1:0]);
  assign stall     = (state != ms_idle);
  assign is_load_q = (op_q == op_lb) || (op_q == op_lh) || (op_q == op_lw) ||
                     (op_q == op_lbu) || (op_q == op_lhu);

  load_align u_align (
    .rdata    (bus.rdata),
    .op       (op_q),
    .byte_off (bus.addr[1:0]),
    .result   (ld_result)
  );

  // --------------------------------------------------
  // handshake control
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= ms_idle;
      bus.req  <= 1'b0;
      wb_valid <= 1'b0;
      exc      <= 1'b0;
      kill     <= 1'b0;
    end else begin
      wb_valid <= 1'b0;
      exc      <= 1'b0;
      case (state)
        ms_idle: begin
          if (accept && bad_align) begin
            exc <= ~flush; // exception instead of a bus access
          end else if (accept && in_op != op_none) begin
            bus.req <= 1'b1;
            kill    <= flush;
            state   <= ms_req;
          end
        end
        ms_req: begin
          kill <= kill | flush;
          if (bus.ack) begin
            bus.req <= 1'b0;
            state   <= ms_rel;
          end
        end
        default: begin
          kill <= kill | flush;
          if (!bus.ack) begin
            wb_valid <= is_load_q && (wb_rd != 5'd0) && !kill && !flush; // no write to x0
            state    <= ms_idle;
          end
        end
      endcase
    end
  end

  // --------------------------------------------------
  // operation payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= in_op;
      wb_rd    <= in_rd;
      bus.addr <= in_addr;
      exc_addr <= in_addr;
      bus.we   <= (in_op == op_sb) || (in_op == op_sh) || (in_op == op_sw);
      case (in_op)
        op_sb: begin
          bus.wdata <= {4{in_sdata[7:0]}};
          bus.wstrb <= 4'b0001 << in_addr[1:0];
        end
        op_sh: begin
          bus.wdata <= {2{in_sdata[15:0]}};
          bus.wstrb <= in_addr[1] ? 4'b1100 : 4'b0011;
        end
        op_sw: begin
          bus.wdata <= in_sdata;
          bus.wstrb <= 4'b1111;
        end
        default: begin
          bus.wdata <= '0;
          bus.wstrb <= 4'b0000;
        end
      endcase
    end
    if (state == ms_req && bus.ack) begin
      wb_data <= ld_result; // rdata is only valid with ack
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (!rst)
    (bus.req && !bus.ack) |=> (bus.req && $stable(bus.addr) && $stable(bus.we) &&
                              $stable(bus.wdata) && $stable(bus.wstrb)));

endmodule

//--- src/fetch_port.sv
`timescale 1ns/1ps

module fetch_port import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_req,
  input  logic [xlen-1:0] fetch_pc,
  output logic            fetch_busy,
  output logic            fetch_valid,
  output logic [xlen-1:0] fetch_instr,
  mem_bus_if.requester    bus
);

  typedef enum logic [1:0] {fp_idle, fp_req, fp_rel} fp_state_t;

  fp_state_t state;

  assign fetch_busy = (state != fp_idle);
  assign bus.we     = 1'b0; // fetches only read
  assign bus.wdata  = '0;
  assign bus.wstrb  = 4'b0000;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state       <= fp_idle;
      bus.req     <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b0;
      case (state)
        fp_idle: begin
          if (fetch_req) begin
            bus.req <= 1'b1;
            state   <= fp_req;
          end
        end
        fp_req: begin
          if (bus.ack) begin
            bus.req <= 1'b0;
            state   <= fp_rel;
          end
        end
        default: begin
          if (!bus.ack) begin
            fetch_valid <= 1'b1; // word is already held in fetch_instr
            state       <= fp_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == fp_idle && fetch_req) begin
      bus.addr <= {fetch_pc[xlen-1:2], 2'b00};
    end
    if (state == fp_req && bus.ack) begin
      fetch_instr <= bus.rdata;
    end
  end

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import mem_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  mem_bus_if.responder fetch_bus,
  mem_bus_if.responder data_bus,
  mem_bus_if.requester ram_bus
);

  arb_state_t      state;
  logic            last_data; // data side got the previous grant
  logic            fetch_ack;
  logic            data_ack;
  logic [xlen-1:0] rdata_q;
  logic            pick_data;
  logic            up_req;
  logic            up_ack;

  // on a tie the side not served last wins
  assign pick_data = data_bus.req && (!fetch_bus.req || !last_data);
  assign up_req    = (state == arb_data) ? data_bus.req : fetch_bus.req;
  assign up_ack    = fetch_ack | data_ack;

  assign fetch_bus.ack   = fetch_ack;
  assign data_bus.ack    = data_ack;
  assign fetch_bus.rdata = fetch_ack ? rdata_q : '0;
  assign data_bus.rdata  = data_ack ? rdata_q : '0;

  // --------------------------------------------------
  // grant and handshake relay
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      state       <= arb_idle;
      last_data   <= 1'b0;
      fetch_ack   <= 1'b0;
      data_ack    <= 1'b0;
      ram_bus.req <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (fetch_bus.req || data_bus.req) begin
            state       <= pick_data ? arb_data : arb_fetch;
            last_data   <= pick_data;
            ram_bus.req <= 1'b1;
          end
        end
        default: begin
          if (ram_bus.req && ram_bus.ack) begin
            fetch_ack <= (state == arb_fetch);
            data_ack  <= (state == arb_data);
          end
          if (up_ack && !up_req) begin
            ram_bus.req <= 1'b0; // requester has released
          end
          if (!ram_bus.req && !ram_bus.ack) begin
            fetch_ack <= 1'b0;
            data_ack  <= 1'b0;
            state     <= arb_idle; // grant held until the RAM drops ack
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == arb_idle) begin
      ram_bus.we    <= pick_data ? data_bus.we    : fetch_bus.we;
      ram_bus.addr  <= pick_data ? data_bus.addr  : fetch_bus.addr;
      ram_bus.wdata <= pick_data ? data_bus.wdata : fetch_bus.wdata;
      ram_bus.wstrb <= pick_data ? data_bus.wstrb : fetch_bus.wstrb;
    end
    if (ram_bus.req && ram_bus.ack) begin
      rdata_q <= ram_bus.rdata;
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (!rst)
    !(fetch_bus.ack && data_bus.ack));

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  mem_bus_if.responder bus
);

  logic [xlen-1:0]   mem [ram_words];
  logic [ram_aw-1:0] idx;

  assign idx = bus.addr[ram_aw+1:2]; // word index, byte offset dropped

  always_ff @(posedge clk) begin
    if (!rst) begin
      bus.ack <= 1'b0;
    end else if (bus.req && !bus.ack) begin
      bus.ack <= 1'b1;
    end else if (!bus.req && bus.ack) begin
      bus.ack <= 1'b0;
    end
  end

  // --------------------------------------------------
  // storage, one access per request
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (bus.req && !bus.ack) begin
      bus.rdata <= mem[idx]; // old contents on a write
      if (bus.we) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.wstrb[i]) begin
            mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  lsu_op_t         in_op,
  input  logic [xlen-1:0] in_addr,
  input  logic [xlen-1:0] in_sdata,
  input  logic [4:0]      in_rd,
  input  logic            flush,
  output logic            stall,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data,
  output logic            exc,
  output logic [xlen-1:0] exc_addr,
  input  logic            fetch_req,
  input  logic [xlen-1:0] fetch_pc,
  output logic            fetch_busy,
  output logic            fetch_valid,
  output logic [xlen-1:0] fetch_instr
);

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();
  mem_bus_if ram_bus ();

  memory_stage u_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_addr  (in_addr),
    .in_sdata (in_sdata),
    .in_rd    (in_rd),
    .flush    (flush),
    .stall    (stall),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .exc      (exc),
    .exc_addr (exc_addr),
    .bus      (data_bus.requester)
  );

  fetch_port u_fetch (
    .clk         (clk),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_pc    (fetch_pc),
    .fetch_busy  (fetch_busy),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .bus         (fetch_bus.requester)
  );

  // both requesters share the one RAM port
  bus_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .fetch_bus (fetch_bus.responder),
    .data_bus  (data_bus.responder),
    .ram_bus   (ram_bus.requester)
  );

  data_ram u_ram (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.responder)
  );

endmodule

//--- tb/tb_tests.svh
// --------------------------------------------------
// reference model
// --------------------------------------------------
function automatic logic [xlen-1:0] word_addr(input int idx);
  word_addr = xlen'(idx % ram_words) << 2;
endfunction

function automatic void model_store(input lsu_op_t op, input logic [xlen-1:0] addr,
                                    input logic [xlen-1:0] data);
  int idx;
  idx = int'(addr[ram_aw+1:2]);
  case (op)
    op_sb:   ref_mem[idx][8*int'(addr[1:0]) +: 8] = data[7:0];
    op_sh:   ref_mem[idx][16*int'(addr[1]) +: 16] = data[15:0];
    op_sw:   ref_mem[idx] = data;
    default: ref_mem[idx] = ref_mem[idx];
  endcase
endfunction

function automatic logic [xlen-1:0] expected_load(input lsu_op_t op, input logic [xlen-1:0] addr);
  logic [xlen-1:0] word;
  logic [7:0]      b;
  logic [15:0]     h;
  word = ref_mem[addr[ram_aw+1:2]];
  b    = word[8*int'(addr[1:0]) +: 8];
  h    = word[16*int'(addr[1]) +: 16];
  case (op)
    op_lb:   expected_load = {{24{b[7]}}, b};
    op_lbu:  expected_load = {24'd0, b};
    op_lh:   expected_load = {{16{h[15]}}, h};
    op_lhu:  expected_load = {16'd0, h};
    default: expected_load = word;
  endcase
endfunction

// --------------------------------------------------
// operation drivers
// --------------------------------------------------
task automatic run_op(input lsu_op_t op, input logic [xlen-1:0] addr,
                      input logic [xlen-1:0] sdata, input logic [4:0] rd,
                      input bit flush_mid, output bit got_wb, output bit got_exc);
  in_valid = 1'b1;
  in_op    = op;
  in_addr  = addr;
  in_sdata = sdata;
  in_rd    = rd;
  @(posedge clk); // stall is low here so the op is taken
  @(negedge clk);
  in_valid = 1'b0;
  flush    = flush_mid && stall; // one-cycle flush while the handshake is open
  while (stall) begin
    @(negedge clk);
    flush = 1'b0;
  end
  got_wb  = wb_valid; // write-back pulses with the fall of stall
  got_exc = exc;
endtask

task automatic do_store(input lsu_op_t op, input logic [xlen-1:0] addr,
                        input logic [xlen-1:0] data);
  bit wb;
  bit ex;
  run_op(op, addr, data, 5'd0, 1'b0, wb, ex);
  if (wb || ex) flag_error($sformatf("store to %h gave a write-back or exception", addr));
  model_store(op, addr, data);
endtask

task automatic do_load(input lsu_op_t op, input logic [xlen-1:0] addr, input logic [4:0] rd);
  bit wb;
  bit ex;
  run_op(op, addr, '0, rd, 1'b0, wb, ex);
  if (!wb) flag_error($sformatf("load from %h gave no write-back", addr));
  else check_wb(rd, expected_load(op, addr));
endtask

task automatic expect_exc(input lsu_op_t op, input logic [xlen-1:0] addr);
  bit wb;
  bit ex;
  run_op(op, addr, next_rand(), 5'd3, 1'b0, wb, ex);
  if (!ex) flag_error($sformatf("misaligned access at %h raised no exception", addr));
  else check_exc(addr);
  if (wb) flag_error($sformatf("misaligned access at %h still wrote back", addr));
endtask

task automatic run_fetch(input logic [xlen-1:0] pc);
  fetch_req = 1'b1;
  fetch_pc  = pc;
  @(posedge clk);
  @(negedge clk);
  fetch_req = 1'b0;
  while (fetch_busy) @(negedge clk);
  if (!fetch_valid) flag_error($sformatf("fetch at %h gave no fetch_valid", pc));
  else check_fetch(ref_mem[pc[ram_aw+1:2]]);
endtask

task automatic report_test(input string name, input int start);
  $display("test %s done, %0d errors", name, errors - start);
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic test_word_round_trip();
  int start;
  start = errors;
  for (int i = 0; i < 8; i++) do_store(op_sw, word_addr(i * 37 + 5), next_rand());
  for (int i = 0; i < 8; i++) do_load(op_lw, word_addr(i * 37 + 5), 5'(i + 1));
  report_test("word round trip", start);
endtask

task automatic test_subword();
  int start;
  logic [xlen-1:0] base;
  logic [xlen-1:0] base2;
  start = errors;
  base  = word_addr(64);
  base2 = word_addr(65);
  do_store(op_sw, base, next_rand());
  do_store(op_sb, base + 1, next_rand() | 32'h80); // negative byte
  do_store(op_sh, base + 2, next_rand() | 32'h8000); // negative half over lanes 2 and 3
  do_store(op_sb, base + 2, next_rand() & 32'h7f); // positive byte below the sign byte
  do_store(op_sw, base2, next_rand());
  do_store(op_sh, base2, next_rand() & 32'h7fff);
  for (int off = 0; off < 4; off++) begin
    do_load(op_lb, base + xlen'(off), 5'd10);
    do_load(op_lbu, base + xlen'(off), 5'd11);
  end
  for (int off = 0; off < 4; off += 2) begin
    do_load(op_lh, base + xlen'(off), 5'd12);
    do_load(op_lhu, base + xlen'(off), 5'd13);
  end
  do_load(op_lh, base2, 5'd14);
  do_load(op_lhu, base2, 5'd15);
  do_load(op_lw, base, 5'd16);
  do_load(op_lw, base2, 5'd17);
  report_test("sub-word stores and loads", start);
endtask

task automatic test_misaligned();
  int start;
  logic [xlen-1:0] addr;
  start = errors;
  addr  = word_addr(5);
  expect_exc(op_lw, addr + 1);
  expect_exc(op_lw, addr + 2);
  expect_exc(op_sh, addr + 1);
  expect_exc(op_sh, addr + 3);
  do_load(op_lw, addr, 5'd9); // contents must be untouched
  report_test("misalignment", start);
endtask

task automatic test_fetch();
  int start;
  start = errors;
  run_fetch(word_addr(42));
  run_fetch(word_addr(42) + 2); // low pc bits are ignored
  report_test("fetch path", start);
endtask

task automatic test_contention();
  int start;
  bit seen_wb;
  bit seen_fetch;
  bit done;
  logic [xlen-1:0] la;
  logic [xlen-1:0] fa;
  start      = errors;
  seen_wb    = 1'b0;
  seen_fetch = 1'b0;
  done       = 1'b0;
  la         = word_addr(79);
  fa         = word_addr(116);
  in_valid   = 1'b1;
  in_op      = op_lw;
  in_addr    = la;
  in_rd      = 5'd12;
  fetch_req  = 1'b1;
  fetch_pc   = fa;
  @(posedge clk);
  @(negedge clk);
  in_valid  = 1'b0;
  fetch_req = 1'b0;
  while (!done) begin
    if (wb_valid) begin
      seen_wb = 1'b1;
      check_wb(5'd12, expected_load(op_lw, la));
    end
    if (fetch_valid) begin
      seen_fetch = 1'b1;
      check_fetch(ref_mem[fa[ram_aw+1:2]]);
    end
    done = !stall && !fetch_busy;
    if (!done) @(negedge clk);
  end
  if (!seen_wb) flag_error("load under contention gave no write-back");
  if (!seen_fetch) flag_error("fetch under contention gave no fetch_valid");
  report_test("contention", start);
endtask

task automatic test_flush_and_x0();
  int start;
  bit wb;
  bit ex;
  logic [xlen-1:0] addr;
  start = errors;
  addr  = word_addr(153);
  run_op(op_lw, addr, '0, 5'd7, 1'b1, wb, ex);
  if (wb || ex) flag_error("flushed load still produced a write-back");
  do_load(op_lw, addr, 5'd8);
  run_op(op_lw, addr, '0, 5'd0, 1'b0, wb, ex);
  if (wb) flag_error("load to x0 produced a write-back");
  do_load(op_lw, addr, 5'd7);
  report_test("flush and x0", start);
endtask

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import mem_pkg::*; ();

  // about 50 operations of at most 15 cycles each, with a margin of four or more
  localparam int max_cycles = 4000;

  logic            clk;
  logic            rst;
  logic            in_valid;
  lsu_op_t         in_op;
  logic [xlen-1:0] in_addr;
  logic [xlen-1:0] in_sdata;
  logic [4:0]      in_rd;
  logic            flush;
  logic            stall;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic [xlen-1:0] wb_data;
  logic            exc;
  logic [xlen-1:0] exc_addr;
  logic            fetch_req;
  logic [xlen-1:0] fetch_pc;
  logic            fetch_busy;
  logic            fetch_valid;
  logic [xlen-1:0] fetch_instr;

  logic [xlen-1:0] ref_mem [ram_words]; // expected RAM contents
  logic [31:0]     lcg_state;
  int              cycles = 0;
  int              checks = 0;
  int              errors = 0;

  mem_subsystem_top DUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // random data and result compares
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    next_rand = lcg_state;
  endfunction

  function automatic void flag_error(input string msg);
    errors++;
    $display("%s", msg);
  endfunction

  task automatic check_wb(input logic [4:0] exp_rd, input logic [xlen-1:0] exp_data);
    checks++;
    if (wb_rd !== exp_rd || wb_data !== exp_data) begin
      errors++;
      $display("Fail at %0t: write-back x%0d = %h, expected x%0d = %h",
               $time, wb_rd, wb_data, exp_rd, exp_data);
    end
  endtask

  task automatic check_exc(input logic [xlen-1:0] exp_addr);
    checks++;
    if (exc_addr !== exp_addr) begin
      errors++;
      $display("Fail at %0t: exc_addr = %h, expected %h", $time, exc_addr, exp_addr);
    end
  endtask

  task automatic check_fetch(input logic [xlen-1:0] exp_instr);
    checks++;
    if (fetch_instr !== exp_instr) begin
      errors++;
      $display("Fail at %0t: fetch_instr = %h, expected %h", $time, fetch_instr, exp_instr);
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    clk       = 1'b0;
    rst       = 1'b0;
    in_valid  = 1'b0;
    in_op     = op_none;
    in_addr   = '0;
    in_sdata  = '0;
    in_rd     = 5'd0;
    flush     = 1'b0;
    fetch_req = 1'b0;
    fetch_pc  = '0;
    lcg_state = 32'd61475;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    test_word_round_trip();
    test_subword();
    test_misaligned();
    test_fetch();
    test_contention();
    test_flush_and_x0();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+tb
src/mem_pkg.sv
src/mem_bus_if.sv
src/load_align.sv
src/memory_stage.sv
src/fetch_port.sv
src/bus_arbiter.sv
src/data_ram.sv
src/mem_subsystem_top.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f all.f \
  && ./obj_dir/Vtb_top | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
